// File: tb.f
src/ex_pkg.sv
src/alu_core.sv
src/branch_unit.sv
src/ex_mem_reg.sv
src/ex_stage.sv
+incdir+verification
verification/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f tb.f --top-module tb_ex_stage -o sim_ex_stage &&
./obj_dir/sim_ex_stage | tee /dev/stderr | grep -q "TEST PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: verification/tb_ex_model.svh
/* testbench model for the execute stage
   lfsr source, expected value functions and typed compare tasks */
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic ex_pkg::word_t rand_bits(input int n);
  ex_pkg::word_t v;
  logic          fb;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    v          = {v[30:0], fb};
  end
  return v;
endfunction

function automatic ex_pkg::word_t model_result(input ex_pkg::alu_op_e op, input logic [2:0] f3,
    input logic f7b, input ex_pkg::word_t a, input ex_pkg::word_t b,
    input ex_pkg::word_t imm, input ex_pkg::word_t pc);
  ex_pkg::word_t y;
  int            sh;
  y = (op == ex_pkg::OP_REG) ? b : imm;         // second operand
  sh = int'(y[4:0]);
  case (op)
    ex_pkg::OP_MEM:   return a + imm;
    ex_pkg::OP_LUI:   return imm;
    ex_pkg::OP_AUIPC: return pc + imm;
    ex_pkg::OP_JAL,
    ex_pkg::OP_JALR:  return pc + 32'd4;           // link value
    ex_pkg::OP_BRANCH: return '0;
    default:
    begin
      case (f3)
        3'd0: return (op == ex_pkg::OP_REG && f7b) ? a - y : a + y;
        3'd1: return a << sh;
        3'd2: return {31'd0, $signed(a) < $signed(y)};
        3'd3: return {31'd0, a < y};
        3'd4: return a ^ y;
        3'd5: return f7b ? ex_pkg::word_t'($signed(a) >>> sh) : a >> sh;
        3'd6: return a | y;
        default: return a & y;
      endcase
    end
  endcase
endfunction

function automatic logic model_redirect(input ex_pkg::alu_op_e op, input logic [2:0] f3,
    input ex_pkg::word_t a, input ex_pkg::word_t b);
  if (op == ex_pkg::OP_JAL || op == ex_pkg::OP_JALR)
    return 1'b1;
  if (op != ex_pkg::OP_BRANCH)
    return 1'b0;
  case (f3)
    ex_pkg::F3_BEQ:  return a == b;
    ex_pkg::F3_BNE:  return a != b;
    ex_pkg::F3_BLT:  return $signed(a) < $signed(b);
    ex_pkg::F3_BGE:  return $signed(a) >= $signed(b);
    ex_pkg::F3_BLTU: return a < b;
    ex_pkg::F3_BGEU: return a >= b;
    default:         return 1'b0;
  endcase
endfunction

function automatic ex_pkg::word_t model_target(input ex_pkg::alu_op_e op,
    input ex_pkg::word_t a, input ex_pkg::word_t imm, input ex_pkg::word_t pc);
  ex_pkg::word_t s;
  s = a + imm;
  if (op == ex_pkg::OP_JALR)
    return {s[31:1], 1'b0};                      // bit 0 cleared
  return pc + imm;
endfunction

function automatic ex_pkg::byte_en_t model_be(input logic [2:0] f3, input logic [1:0] off,
    input logic mem);
  ex_pkg::byte_en_t m;
  if (!mem)
    return 4'b0000;
  case (f3)
    ex_pkg::F3_BYTE, ex_pkg::F3_BYTE_U: m = 4'b0001;
    ex_pkg::F3_HALF, ex_pkg::F3_HALF_U: m = 4'b0011;
    ex_pkg::F3_WORD:                    m = 4'b1111;
    default:                            m = 4'b0000;
  endcase
  return m << off;
endfunction

task automatic check_word(input string what, input ex_pkg::word_t got, input ex_pkg::word_t exp);
  if (got !== exp)
  begin
    fail_cnt++;
    $display("[FAIL] %0t %s got %h expected %h", $time, what, got, exp);
  end
  else
    pass_cnt++;
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
  if (got !== exp)
  begin
    fail_cnt++;
    $display("[FAIL] %0t %s got %b expected %b", $time, what, got, exp);
  end
  else
    pass_cnt++;
endtask

task automatic check_be(input string what, input ex_pkg::byte_en_t got,
    input ex_pkg::byte_en_t exp);
  if (got !== exp)
  begin
    fail_cnt++;
    $display("[FAIL] %0t %s got %b expected %b", $time, what, got, exp);
  end
  else
    pass_cnt++;
endtask

`endif

// File: verification/tb_ex_stage.sv
/* testbench for the execute stage, directed tests with lfsr operands */
`timescale 1ns/1ps

module tb_ex_stage;

  logic             i_clk;
  logic             i_reset;
  logic             i_valid;
  ex_pkg::alu_op_e  i_alu_op;
  logic [2:0]       i_funct3;
  logic             i_funct7b;
  ex_pkg::word_t    i_a;
  ex_pkg::word_t    i_b;
  ex_pkg::word_t    i_imm;
  ex_pkg::word_t    i_pc;
  ex_pkg::reg_idx_t i_rd;
  logic             i_reg_write;
  logic             i_mem_read;
  logic             i_mem_write;
  logic             i_mem_to_reg;
  logic             o_valid;
  ex_pkg::word_t    o_result;
  ex_pkg::word_t    o_store_data;
  ex_pkg::byte_en_t o_byte_en;
  ex_pkg::reg_idx_t o_rd;
  logic             o_reg_write;
  logic             o_mem_read;
  logic             o_mem_write;
  logic             o_mem_to_reg;
  logic             o_redirect;
  ex_pkg::word_t    o_redirect_pc;
  ex_pkg::word_t    lfsr_state = 32'h912e_59ec;
  int               pass_cnt = 0;
  int               fail_cnt = 0;
  int               mark;

  `include "tb_ex_model.svh"

  ex_stage DUT (.*);

  always #20 i_clk = ~i_clk;                     // 40 ns period

  task automatic check_idle(input string when);
    check_bit({when, " o_valid"}, o_valid, 1'b0);
    check_bit({when, " o_reg_write"}, o_reg_write, 1'b0);
    check_bit({when, " o_mem_read"}, o_mem_read, 1'b0);
    check_bit({when, " o_mem_write"}, o_mem_write, 1'b0);
    check_bit({when, " o_redirect"}, o_redirect, 1'b0);
  endtask

  // drive one instruction at a falling edge, check it one cycle on
  task automatic exec(input ex_pkg::alu_op_e op, input logic [2:0] f3, input logic f7b,
      input ex_pkg::word_t a, input ex_pkg::word_t b, input ex_pkg::word_t imm,
      input ex_pkg::word_t pc, input logic mr, input logic mw);
    ex_pkg::word_t res;
    logic          rdr;
    int            n;
    res = model_result(op, f3, f7b, a, b, imm, pc);
    rdr = model_redirect(op, f3, a, b);
    i_valid      = 1'b1;
    i_alu_op     = op;
    i_funct3     = f3;
    i_funct7b    = f7b;
    i_a          = a;
    i_b          = b;
    i_imm        = imm;
    i_pc         = pc;
    i_rd         = a[4:0];                       // rd borrowed from operand a
    i_reg_write  = !mw;
    i_mem_read   = mr;
    i_mem_write  = mw;
    i_mem_to_reg = mr;
    n = 0;
    do
    begin
      @(negedge i_clk);
      n++;
    end while (!o_valid && n < 8);
    if (!o_valid)
    begin
      $display("timeout: o_valid never rose after an issued instruction");
      $display("TEST FAIL");
      $finish;
    end
    else
    begin
      check_bit("o_valid one cycle after issue", n == 1, 1'b1);
      check_word("o_result", o_result, res);
      check_bit("o_redirect", o_redirect, rdr);
      if (rdr)
        check_word("o_redirect_pc", o_redirect_pc, model_target(op, a, imm, pc));
      check_be("o_byte_en", o_byte_en, model_be(f3, res[1:0], mr || mw));
      if (mw)
        check_word("o_store_data", o_store_data, b << {res[1:0], 3'b000});
      check_word("o_rd", {27'd0, o_rd}, {27'd0, a[4:0]});
      check_bit("o_reg_write", o_reg_write, !mw);
      check_bit("o_mem_read", o_mem_read, mr);
      check_bit("o_mem_write", o_mem_write, mw);
      check_bit("o_mem_to_reg", o_mem_to_reg, mr);
    end
  endtask

  task automatic finish_test(input string name);
    i_valid = 1'b0;                              // bubble between tests
    @(negedge i_clk);
    check_idle(name);
    $display("%s done, %0d failed checks", name, fail_cnt - mark);
    mark = fail_cnt;
  endtask

  task automatic reset_behavior();
    i_valid      = 1'b1;                         // strobe and flags high under reset
    i_alu_op     = ex_pkg::OP_JAL;
    i_reg_write  = 1'b1;
    i_mem_read   = 1'b1;
    i_mem_write  = 1'b1;
    i_mem_to_reg = 1'b1;
    repeat (16)
    begin
      @(negedge i_clk);
      check_idle("reset");
    end
    i_reset = 1'b0;
    i_valid = 1'b0;                              // flags stay high, no strobe
    repeat (3)
    begin
      @(negedge i_clk);
      check_idle("idle");
    end
    finish_test("reset_behavior");
  endtask

  task automatic register_ops();
    for (int f = 0; f < 8; f++)
      for (int s = 0; s < 2; s++)
        if (s == 0 || f == 0 || f == 5)
          exec(ex_pkg::OP_REG, f[2:0], s[0], rand_bits(32), rand_bits(32), '0, '0, 0, 0);
    exec(ex_pkg::OP_REG, 3'd5, 1'b1, 32'h8000_1234, 32'd7, '0, '0, 0, 0);  // sra negative
    finish_test("register_ops");
  endtask

  task automatic immediate_ops();
    ex_pkg::word_t r;
    for (int f = 0; f < 8; f++)
    begin
      r = rand_bits(12);
      exec(ex_pkg::OP_IMM, f[2:0], f == 5, 32'hf000_0000 | rand_bits(28),
           '0, {{20{r[11]}}, r[11:0]}, '0, 0, 0);
    end
    exec(ex_pkg::OP_IMM, 3'd0, 1'b1, rand_bits(32), '0, 32'hffff_fc05, '0, 0, 0);  // addi
    exec(ex_pkg::OP_LUI, 3'd0, 1'b0, '0, '0, rand_bits(20) << 12, '0, 0, 0);
    exec(ex_pkg::OP_AUIPC, 3'd0, 1'b0, '0, '0, rand_bits(20) << 12, rand_bits(32), 0, 0);
    finish_test("immediate_ops");
  endtask

  task automatic branch_conditions();
    ex_pkg::word_t pa [5] = '{32'd5, 32'd3, 32'd7, 32'hffff_fff0, 32'h8000_0000};
    ex_pkg::word_t pb [5] = '{32'd5, 32'd7, 32'd3, 32'd1, 32'h7fff_ffff};
    logic [2:0]    conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    foreach (conds[c])
      foreach (pa[p])
        exec(ex_pkg::OP_BRANCH, conds[c], 1'b0, pa[p], pb[p], 32'hffff_ffe0, 32'h0000_1000,
             0, 0);
    finish_test("branch_conditions");
  endtask

  task automatic jump_targets();
    exec(ex_pkg::OP_JAL, 3'd0, 1'b0, '0, '0, 32'h0000_0100, 32'h0000_2000, 0, 0);
    exec(ex_pkg::OP_JALR, 3'd0, 1'b0, 32'h0000_3001, '0, 32'h0000_0010, 32'h0000_2004, 0, 0);
    exec(ex_pkg::OP_JALR, 3'd0, 1'b0, 32'h0000_4000, '0, 32'hffff_fffc, 32'h0000_2008, 0, 0);
    finish_test("jump_targets");
  endtask

  task automatic memory_access();
    logic [2:0] w [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    foreach (w[k])
      for (int off = 0; off < 4; off++)
        if (w[k] == 3'd0 || w[k] == 3'd4 || (w[k] != 3'd2 && off[0] == 0) || off == 0)
        begin
          if (w[k] < 3'd3)
            exec(ex_pkg::OP_MEM, w[k], 1'b0, 32'h0000_8000, rand_bits(32), off, '0, 0, 1);
          exec(ex_pkg::OP_MEM, w[k], 1'b0, 32'h0000_9000, '0, off, '0, 1, 0);
        end
    finish_test("memory_access");
  endtask

  initial
  begin
    i_clk        = 0;
    i_reset      = 1;
    i_valid      = 0;
    i_alu_op     = ex_pkg::OP_MEM;
    i_funct3     = '0;
    i_funct7b    = 0;
    i_a          = '0;
    i_b          = '0;
    i_imm        = '0;
    i_pc         = '0;
    i_rd         = '0;
    i_reg_write  = 0;
    i_mem_read   = 0;
    i_mem_write  = 0;
    i_mem_to_reg = 0;
    mark         = 0;
    reset_behavior();
    register_ops();
    immediate_ops();
    branch_conditions();
    jump_targets();
    memory_access();
    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: src/ex_stage.sv
/* execute stage top: alu, branch unit and ex/mem register */
`timescale 1ns/1ps

module ex_stage
(
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_valid,         // one strobe per instruction
  input  ex_pkg::alu_op_e  i_alu_op,
  input  logic [2:0]       i_funct3,
  input  logic             i_funct7b,
  input  ex_pkg::word_t    i_a,
  input  ex_pkg::word_t    i_b,
  input  ex_pkg::word_t    i_imm,
  input  ex_pkg::word_t    i_pc,
  input  ex_pkg::reg_idx_t i_rd,
  input  logic             i_reg_write,
  input  logic             i_mem_read,
  input  logic             i_mem_write,
  input  logic             i_mem_to_reg,
  output logic             o_valid,
  output ex_pkg::word_t    o_result,
  output ex_pkg::word_t    o_store_data,
  output ex_pkg::byte_en_t o_byte_en,
  output ex_pkg::reg_idx_t o_rd,
  output logic             o_reg_write,
  output logic             o_mem_read,
  output logic             o_mem_write,
  output logic             o_mem_to_reg,
  output logic             o_redirect,
  output ex_pkg::word_t    o_redirect_pc
);

  ex_pkg::word_t a_result;                   // arithmetic side
  ex_pkg::word_t br_target;
  ex_pkg::word_t br_link;
  logic          br_redirect;
  logic          br_link_sel;

  alu_core u_alu_core
  (
    .i_alu_op  (i_alu_op),
    .i_funct3  (i_funct3),
    .i_funct7b (i_funct7b),
    .i_a       (i_a),
    .i_b       (i_b),
    .i_imm     (i_imm),
    .i_pc      (i_pc),
    .o_result  (a_result)
  );

  branch_unit u_branch_unit
  (
    .i_valid    (i_valid),
    .i_alu_op   (i_alu_op),
    .i_funct3   (i_funct3),
    .i_a        (i_a),
    .i_b        (i_b),
    .i_imm      (i_imm),
    .i_pc       (i_pc),
    .o_redirect (br_redirect),
    .o_target   (br_target),
    .o_link     (br_link),
    .o_link_sel (br_link_sel)
  );

  ex_mem_reg u_ex_mem_reg
  (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_valid       (i_valid),
    .i_alu_result  (a_result),
    .i_link        (br_link),
    .i_link_sel    (br_link_sel),
    .i_redirect    (br_redirect),
    .i_target      (br_target),
    .i_store_src   (i_b),                    // rs2 feeds store data
    .i_funct3      (i_funct3),
    .i_rd          (i_rd),
    .i_reg_write   (i_reg_write),
    .i_mem_read    (i_mem_read),
    .i_mem_write   (i_mem_write),
    .i_mem_to_reg  (i_mem_to_reg),
    .o_valid       (o_valid),
    .o_result      (o_result),
    .o_store_data  (o_store_data),
    .o_byte_en     (o_byte_en),
    .o_rd          (o_rd),
    .o_reg_write   (o_reg_write),
    .o_mem_read    (o_mem_read),
    .o_mem_write   (o_mem_write),
    .o_mem_to_reg  (o_mem_to_reg),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

endmodule

// File: src/ex_mem_reg.sv
/* execute-to-memory register
   merges results, aligns store lanes and byte enables, registers outputs */
`timescale 1ns/1ps

module ex_mem_reg
(
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_valid,
  input  ex_pkg::word_t    i_alu_result,
  input  ex_pkg::word_t    i_link,
  input  logic             i_link_sel,
  input  logic             i_redirect,
  input  ex_pkg::word_t    i_target,
  input  ex_pkg::word_t    i_store_src,     // rs2 value for stores
  input  logic [2:0]       i_funct3,        // access width
  input  ex_pkg::reg_idx_t i_rd,
  input  logic             i_reg_write,
  input  logic             i_mem_read,
  input  logic             i_mem_write,
  input  logic             i_mem_to_reg,
  output logic             o_valid,
  output ex_pkg::word_t    o_result,
  output ex_pkg::word_t    o_store_data,
  output ex_pkg::byte_en_t o_byte_en,
  output ex_pkg::reg_idx_t o_rd,
  output logic             o_reg_write,
  output logic             o_mem_read,
  output logic             o_mem_write,
  output logic             o_mem_to_reg,
  output logic             o_redirect,
  output ex_pkg::word_t    o_redirect_pc
);

  ex_pkg::word_t    result;
  ex_pkg::word_t    store_lane;
  ex_pkg::byte_en_t width_mask;
  ex_pkg::byte_en_t byte_en;
  logic [1:0]       offset;               // byte offset within word
  logic             mem_acc;

  assign result  = i_link_sel ? i_link : i_alu_result;
  assign offset  = result[1:0];
  assign mem_acc = i_valid && (i_mem_read || i_mem_write);

  always_comb
  begin
    case (i_funct3)
      ex_pkg::F3_BYTE,
      ex_pkg::F3_BYTE_U: width_mask = 4'b0001;
      ex_pkg::F3_HALF,
      ex_pkg::F3_HALF_U: width_mask = 4'b0011;
      ex_pkg::F3_WORD:   width_mask = 4'b1111;
      default:           width_mask = 4'b0000;
    endcase
  end

  assign byte_en    = mem_acc ? (width_mask << offset) : 4'b0000;
  assign store_lane = i_store_src << {offset, 3'b000};   // shift into lanes

  // control flags, dropped on bubbles
  always_ff @(posedge i_clk)
  begin
    if (i_reset)
    begin
      o_valid      <= 1'b0;
      o_reg_write  <= 1'b0;
      o_mem_read   <= 1'b0;
      o_mem_write  <= 1'b0;
      o_mem_to_reg <= 1'b0;
      o_redirect   <= 1'b0;
      o_byte_en    <= '0;
    end
    else
    begin
      o_valid      <= i_valid;
      o_reg_write  <= i_valid && i_reg_write;
      o_mem_read   <= i_valid && i_mem_read;
      o_mem_write  <= i_valid && i_mem_write;
      o_mem_to_reg <= i_valid && i_mem_to_reg;
      o_redirect   <= i_valid && i_redirect;
      o_byte_en    <= byte_en;
    end
  end

  // payload, qualified by o_valid downstream
  always_ff @(posedge i_clk)
  begin
    o_result      <= result;
    o_store_data  <= store_lane;
    o_rd          <= i_rd;
    o_redirect_pc <= i_target;
  end

endmodule

// File: src/branch_unit.sv
/* branch unit: condition compare, branch/jump target and link value */
`timescale 1ns/1ps

module branch_unit
(
  input  logic            i_valid,
  input  ex_pkg::alu_op_e i_alu_op,
  input  logic [2:0]      i_funct3,          // branch condition
  input  ex_pkg::word_t   i_a,
  input  ex_pkg::word_t   i_b,
  input  ex_pkg::word_t   i_imm,
  input  ex_pkg::word_t   i_pc,
  output logic            o_redirect,        // fetch must restart at o_target
  output ex_pkg::word_t   o_target,
  output ex_pkg::word_t   o_link,            // return address for jal/jalr
  output logic            o_link_sel         // high for jal/jalr
);

  ex_pkg::word_t jalr_sum;
  logic          is_branch;
  logic          is_jal;
  logic          is_jalr;
  logic          taken;
  logic          eq;
  logic          lt_s;
  logic          lt_u;

  assign is_branch = (i_alu_op == ex_pkg::OP_BRANCH);
  assign is_jal    = (i_alu_op == ex_pkg::OP_JAL);
  assign is_jalr   = (i_alu_op == ex_pkg::OP_JALR);

  assign eq   = (i_a == i_b);
  assign lt_s = ($signed(i_a) < $signed(i_b));
  assign lt_u = (i_a < i_b);

  always_comb
  begin
    case (i_funct3)
      ex_pkg::F3_BEQ:  taken = eq;
      ex_pkg::F3_BNE:  taken = !eq;
      ex_pkg::F3_BLT:  taken = lt_s;
      ex_pkg::F3_BGE:  taken = !lt_s;
      ex_pkg::F3_BLTU: taken = lt_u;
      ex_pkg::F3_BGEU: taken = !lt_u;
      default:         taken = 1'b0;     // reserved codes never taken
    endcase
  end

  assign jalr_sum = i_a + i_imm;

  // jalr clears bit 0, branch and jal are pc relative
  assign o_target = is_jalr ? {jalr_sum[ex_pkg::XLEN-1:1], 1'b0} : (i_pc + i_imm);

  assign o_link     = i_pc + ex_pkg::PC_STEP;   // next sequential pc
  assign o_link_sel = is_jal || is_jalr;

  assign o_redirect = i_valid && ((is_branch && taken) || is_jal || is_jalr);

endmodule

// File: src/alu_core.sv
/* arithmetic unit of the execute stage
   register, immediate, address, LUI and AUIPC results */
`timescale 1ns/1ps

module alu_core
(
  input  ex_pkg::alu_op_e i_alu_op,          // operation class
  input  logic [2:0]      i_funct3,
  input  logic            i_funct7b,         // instr bit 30, sub/sra select
  input  ex_pkg::word_t   i_a,
  input  ex_pkg::word_t   i_b,
  input  ex_pkg::word_t   i_imm,             // sign extended immediate
  input  ex_pkg::word_t   i_pc,
  output ex_pkg::word_t   o_result
);

  ex_pkg::word_t op_b;                       // second operand
  ex_pkg::word_t add_sub;
  ex_pkg::word_t logic_res;                  // reg/imm class result
  logic [4:0]    shamt;
  logic          is_reg;
  logic          lt_s;
  logic          lt_u;

  assign is_reg = (i_alu_op == ex_pkg::OP_REG);
  assign op_b   = is_reg ? i_b : i_imm;
  assign shamt  = op_b[4:0];                 // low five bits only

  // subtract only for register ops, addi ignores bit 30
  assign add_sub = (is_reg && i_funct7b) ? (i_a - op_b) : (i_a + op_b);

  assign lt_s = ($signed(i_a) < $signed(op_b));
  assign lt_u = (i_a < op_b);

  always_comb
  begin
    logic_res = '0;
    case (i_funct3)
      3'd0: logic_res = add_sub;             // add / sub
      3'd1: logic_res = i_a << shamt;        // sll
      3'd2: logic_res[0] = lt_s;             // slt
      3'd3: logic_res[0] = lt_u;             // sltu
      3'd4: logic_res = i_a ^ op_b;          // xor
      3'd5:
      begin
        if (i_funct7b)
        begin
          logic_res = $signed(i_a) >>> shamt; // sra, sign filled
        end
        else
        begin
          logic_res = i_a >> shamt;          // srl
        end
      end
      3'd6: logic_res = i_a | op_b;          // or
      3'd7: logic_res = i_a & op_b;          // and
      default: logic_res = '0;
    endcase
  end

  // class select
  always_comb
  begin
    case (i_alu_op)
      ex_pkg::OP_REG,
      ex_pkg::OP_IMM:   o_result = logic_res;
      ex_pkg::OP_MEM:   o_result = i_a + i_imm;   // effective address
      ex_pkg::OP_LUI:   o_result = i_imm;         // upper imm already placed
      ex_pkg::OP_AUIPC: o_result = i_pc + i_imm;
      default:          o_result = '0;            // branch and jumps use link path
    endcase
  end

endmodule

// File: src/ex_pkg.sv
/* execute stage shared definitions
   word type, operation classes, funct3 codes and lane types */
package ex_pkg;

  localparam int XLEN = 32;                  // integer word width

  typedef logic [XLEN-1:0] word_t;           // operands, pcs, results
  typedef logic [3:0]      byte_en_t;        // one bit per byte lane
  typedef logic [4:0]      reg_idx_t;        // destination register

  // operation class from decode
  typedef enum logic [2:0]
  {
    OP_MEM    = 3'd0,                        // load/store address
    OP_BRANCH = 3'd1,
    OP_REG    = 3'd2,
    OP_IMM    = 3'd3,
    OP_LUI    = 3'd4,
    OP_AUIPC  = 3'd5,
    OP_JAL    = 3'd6,
    OP_JALR   = 3'd7
  } alu_op_e;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'd0;
  localparam logic [2:0] F3_BNE  = 3'd1;
  localparam logic [2:0] F3_BLT  = 3'd4;
  localparam logic [2:0] F3_BGE  = 3'd5;
  localparam logic [2:0] F3_BLTU = 3'd6;
  localparam logic [2:0] F3_BGEU = 3'd7;

  // load/store access widths
  localparam logic [2:0] F3_BYTE   = 3'd0;
  localparam logic [2:0] F3_HALF   = 3'd1;
  localparam logic [2:0] F3_WORD   = 3'd2;
  localparam logic [2:0] F3_BYTE_U = 3'd4;
  localparam logic [2:0] F3_HALF_U = 3'd5;

  localparam word_t PC_STEP = 32'd4;         // instruction size in bytes

endpackage
